// File: hw/adc_pkg.sv
package adc_pkg;

  // Sample geometry
  localparam int SAMPLE_BITS      = 10;
  localparam int PAIRS_PER_SAMPLE = SAMPLE_BITS / 2;

  // One assembled ADC sample
  typedef logic [SAMPLE_BITS-1:0] sample_t;

  // DDR pair from one lane, bit 1 is the rising-edge bit
  typedef logic [1:0] bit_pair_t;

  // Saturating frame-error count per lane
  typedef logic [15:0] err_cnt_t;

  // Register bus
  typedef logic [31:0] bus_data_t;
  typedef logic [11:0] bus_addr_t;  // Word address

  // Snapshot capture FSM
  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURING,
    DONE
  } capture_state_t;

endpackage

// File: hw/lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer #(
  parameter int NUM_LANES = 2
) (
  input  logic                                  fclk_ctr_clk,
  input  logic                                  rst,
  input  adc_pkg::bit_pair_t [NUM_LANES-1:0]    lane_bits_i,
  input  logic                                  frame_i,
  output adc_pkg::sample_t   [NUM_LANES-1:0]    samples_o,
  output logic                                  sample_valid_o,
  output adc_pkg::err_cnt_t  [NUM_LANES-1:0]    err_cnt_o
);

  localparam int SHIFT_BITS = adc_pkg::SAMPLE_BITS - 2;  // Pairs 0 to 3
  localparam int LAST_PAIR  = adc_pkg::PAIRS_PER_SAMPLE - 1;

  logic [2:0] pair_cnt_q;
  logic       in_sync_q;   // Seen a frame strobe since reset
  logic       frame_err;
  logic       last_pair;

  logic [NUM_LANES-1:0][SHIFT_BITS-1:0] shift_q;

  // Strobe on any pair other than pair 0 means the lanes slipped
  assign frame_err = frame_i && in_sync_q && (pair_cnt_q != 3'd0);

  // Fifth pair on the wire, and no realignment this cycle
  assign last_pair = in_sync_q && !frame_i && (pair_cnt_q == 3'(LAST_PAIR));

  // Shared pair counter
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      in_sync_q      <= 1'b0;
      pair_cnt_q     <= 3'd0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= last_pair;
      if (frame_i) begin
        // The pair on this cycle is pair 0
        in_sync_q  <= 1'b1;
        pair_cnt_q <= 3'd1;
      end else if (in_sync_q) begin
        if (last_pair) begin
          pair_cnt_q <= 3'd0;
        end else begin
          pair_cnt_q <= pair_cnt_q + 3'd1;
        end
      end
    end
  end

  // Old pairs fall off the top, so a partial sample is
  // overwritten before the next load
  always_ff @(posedge fclk_ctr_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      shift_q[l] <= {shift_q[l][SHIFT_BITS-3:0], lane_bits_i[l]};
      if (last_pair) begin
        samples_o[l] <= {shift_q[l], lane_bits_i[l]};  // MS pair first
      end
    end
  end

  // Per-lane error counters, stick at all ones
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      err_cnt_o <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (frame_err && (err_cnt_o[l] != '1)) begin
          err_cnt_o[l] <= err_cnt_o[l] + 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/snapshot_ctrl.sv
`timescale 1ns/1ps

module snapshot_ctrl #(
  parameter int SNAP_ADDR_BITS = 6
) (
  input  logic                      fclk_ctr_clk,
  input  logic                      rst,
  input  logic                      sw_trig_i,
  input  logic                      ext_trig_i,
  input  logic                      sample_valid_i,
  output logic                      snap_we_o,
  output logic [SNAP_ADDR_BITS-1:0] snap_addr_o,
  output logic                      busy_o,
  output logic                      done_o
);

  adc_pkg::capture_state_t state_q;
  adc_pkg::capture_state_t state_d;

  logic [SNAP_ADDR_BITS-1:0] addr_q;
  logic sw_trig_q;
  logic ext_meta_q;     // First synchronizer flop
  logic ext_sync_q;
  logic ext_sync_d1_q;  // For the edge detect
  logic trig_pulse;
  logic can_arm;
  logic in_capture;

  assign trig_pulse = (sw_trig_i & ~sw_trig_q) | (ext_sync_q & ~ext_sync_d1_q);
  assign can_arm    = (state_q == adc_pkg::IDLE) || (state_q == adc_pkg::DONE);
  assign in_capture = (state_q == adc_pkg::ARMED) || (state_q == adc_pkg::CAPTURING);

  // Armed counts too, the first sample after the trigger goes to address 0
  assign snap_we_o   = sample_valid_i && in_capture;
  assign snap_addr_o = addr_q;
  assign busy_o      = in_capture;
  assign done_o      = (state_q == adc_pkg::DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      adc_pkg::IDLE,
      adc_pkg::DONE:      if (trig_pulse) state_d = adc_pkg::ARMED;
      adc_pkg::ARMED:     if (sample_valid_i) state_d = adc_pkg::CAPTURING;
      adc_pkg::CAPTURING: if (sample_valid_i && (&addr_q)) state_d = adc_pkg::DONE;
      default:            state_d = adc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      state_q       <= adc_pkg::IDLE;
      addr_q        <= '0;
      sw_trig_q     <= 1'b0;
      ext_meta_q    <= 1'b0;
      ext_sync_q    <= 1'b0;
      ext_sync_d1_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      sw_trig_q     <= sw_trig_i;
      ext_meta_q    <= ext_trig_i;
      ext_sync_q    <= ext_meta_q;
      ext_sync_d1_q <= ext_sync_q;
      if (trig_pulse && can_arm) begin
        addr_q <= '0;
      end else if (snap_we_o) begin
        addr_q <= addr_q + 1'b1;  // Wraps to 0 after the last write
      end
    end
  end

endmodule

// File: hw/snapshot_buffer.sv
`timescale 1ns/1ps

module snapshot_buffer #(
  parameter int NUM_LANES      = 2,
  parameter int SNAP_ADDR_BITS = 6
) (
  input  logic                                fclk_ctr_clk,
  input  logic                                we_i,
  input  logic [SNAP_ADDR_BITS-1:0]           wr_addr_i,
  input  adc_pkg::sample_t [NUM_LANES-1:0]    samples_i,
  input  logic [SNAP_ADDR_BITS-1:0]           rd_addr_i,
  output adc_pkg::sample_t [NUM_LANES-1:0]    rd_data_o
);

  localparam int DEPTH = 1 << SNAP_ADDR_BITS;

  // One word holds all lanes of one sample period
  adc_pkg::sample_t [NUM_LANES-1:0] mem_q [DEPTH];

  // Capture side
  always_ff @(posedge fclk_ctr_clk) begin
    if (we_i) begin
      mem_q[wr_addr_i] <= samples_i;
    end
  end

  // Bus side, registered read
  always_ff @(posedge fclk_ctr_clk) begin
    rd_data_o <= mem_q[rd_addr_i];
  end

endmodule

// File: hw/adc_regs.sv
`timescale 1ns/1ps

module adc_regs #(
  parameter int NUM_LANES      = 2,
  parameter int SNAP_ADDR_BITS = 6
) (
  input  logic                                 fclk_ctr_clk,
  input  logic                                 rst,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  adc_pkg::bus_addr_t                   wb_adr_i,
  input  adc_pkg::bus_data_t                   wb_dat_i,
  input  logic                                 busy_i,
  input  logic                                 done_i,
  input  adc_pkg::err_cnt_t [NUM_LANES-1:0]    err_cnt_i,
  input  adc_pkg::sample_t  [NUM_LANES-1:0]    buf_data_i,
  output logic                                 wb_ack_o,
  output adc_pkg::bus_data_t                   wb_dat_o,
  output logic                                 sw_trig_o,
  output logic [SNAP_ADDR_BITS-1:0]            buf_addr_o
);

  localparam adc_pkg::bus_addr_t CTRL_ADDR   = 12'h000;
  localparam adc_pkg::bus_addr_t STATUS_ADDR = 12'h001;
  localparam adc_pkg::bus_addr_t ERR_BASE    = 12'h004;
  localparam int ERR_BITS = $bits(adc_pkg::err_cnt_t);
  localparam int BUF_BITS = NUM_LANES * adc_pkg::SAMPLE_BITS;

  logic               s1_q;       // Access in first stage
  logic               start;
  adc_pkg::bus_addr_t adr_q;
  logic               we_q;
  adc_pkg::bus_data_t dat_q;
  logic               ctrl_q;
  logic               is_buf;
  logic               sel_buf_q;  // Second stage returns a buffer word
  adc_pkg::bus_data_t reg_word;
  adc_pkg::bus_data_t rd_q;
  adc_pkg::bus_data_t buf_word;

  // Held stb during ack must not open a second access
  assign start = wb_cyc_i && wb_stb_i && !s1_q && !wb_ack_o;

  // 0x800 window, only as deep as the buffer
  assign is_buf = adr_q[11] && ((adr_q[10:0] >> SNAP_ADDR_BITS) == '0);

  assign buf_addr_o = adr_q[SNAP_ADDR_BITS-1:0];
  assign sw_trig_o  = ctrl_q;

  always_comb begin
    reg_word = '0;
    if (adr_q == CTRL_ADDR) begin
      reg_word[0] = ctrl_q;
    end else if (adr_q == STATUS_ADDR) begin
      reg_word[0] = busy_i;
      reg_word[1] = done_i;
    end
    for (int n = 0; n < NUM_LANES; n++) begin
      if (adr_q == ERR_BASE + adc_pkg::bus_addr_t'(n)) begin
        reg_word[ERR_BITS-1:0] = err_cnt_i[n];
      end
    end
  end

  // Lane n sits in bits 10n+9 down to 10n
  always_comb begin
    buf_word = '0;
    buf_word[BUF_BITS-1:0] = buf_data_i;
  end

  // Buffer data arrives with the ack, so it is muxed in late
  assign wb_dat_o = sel_buf_q ? buf_word : rd_q;

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      s1_q      <= 1'b0;
      wb_ack_o  <= 1'b0;
      ctrl_q    <= 1'b0;
      sel_buf_q <= 1'b0;
    end else begin
      s1_q     <= start;
      wb_ack_o <= s1_q;
      if (s1_q) begin
        sel_buf_q <= is_buf;
        if (we_q && (adr_q == CTRL_ADDR)) begin
          ctrl_q <= dat_q[0];  // Visible in the ack cycle
        end
      end
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (start) begin
      adr_q <= wb_adr_i;
      we_q  <= wb_we_i;
      dat_q <= wb_dat_i;
    end
    if (s1_q) begin
      rd_q <= reg_word;
    end
  end

endmodule

// File: hw/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top #(
  parameter int NUM_LANES      = 2,  // 1 to 3, one buffer word per bus word
  parameter int SNAP_ADDR_BITS = 6
) (
  input  logic                                 fclk_ctr_clk,
  input  logic                                 rst,
  input  adc_pkg::bit_pair_t [NUM_LANES-1:0]   lane_bits_i,
  input  logic                                 frame_i,
  input  logic                                 ext_trig_i,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  adc_pkg::bus_addr_t                   wb_adr_i,
  input  adc_pkg::bus_data_t                   wb_dat_i,
  output adc_pkg::sample_t   [NUM_LANES-1:0]   samples_o,
  output logic                                 sample_valid_o,
  output logic                                 snap_we_o,
  output logic [SNAP_ADDR_BITS-1:0]            snap_addr_o,
  output logic                                 wb_ack_o,
  output adc_pkg::bus_data_t                   wb_dat_o
);

  adc_pkg::err_cnt_t [NUM_LANES-1:0] err_cnt;
  adc_pkg::sample_t  [NUM_LANES-1:0] buf_data;
  logic [SNAP_ADDR_BITS-1:0]         buf_addr;
  logic sw_trig;
  logic busy;
  logic done;

  lane_deserializer #(
    .NUM_LANES (NUM_LANES)
  ) u_deser (
    .fclk_ctr_clk   (fclk_ctr_clk),
    .rst            (rst),
    .lane_bits_i    (lane_bits_i),
    .frame_i        (frame_i),
    .samples_o      (samples_o),
    .sample_valid_o (sample_valid_o),
    .err_cnt_o      (err_cnt)
  );

  snapshot_ctrl #(
    .SNAP_ADDR_BITS (SNAP_ADDR_BITS)
  ) u_snap_ctrl (
    .fclk_ctr_clk   (fclk_ctr_clk),
    .rst            (rst),
    .sw_trig_i      (sw_trig),
    .ext_trig_i     (ext_trig_i),
    .sample_valid_i (sample_valid_o),
    .snap_we_o      (snap_we_o),
    .snap_addr_o    (snap_addr_o),
    .busy_o         (busy),
    .done_o         (done)
  );

  // Written with the samples of the same cycle as the strobe
  snapshot_buffer #(
    .NUM_LANES      (NUM_LANES),
    .SNAP_ADDR_BITS (SNAP_ADDR_BITS)
  ) u_snap_buf (
    .fclk_ctr_clk (fclk_ctr_clk),
    .we_i         (snap_we_o),
    .wr_addr_i    (snap_addr_o),
    .samples_i    (samples_o),
    .rd_addr_i    (buf_addr),
    .rd_data_o    (buf_data)
  );

  adc_regs #(
    .NUM_LANES      (NUM_LANES),
    .SNAP_ADDR_BITS (SNAP_ADDR_BITS)
  ) u_regs (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .busy_i       (busy),
    .done_i       (done),
    .err_cnt_i    (err_cnt),
    .buf_data_i   (buf_data),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .sw_trig_o    (sw_trig),
    .buf_addr_o   (buf_addr)
  );

endmodule

// File: testbench/adc_capture_asserts.sv
`timescale 1ns/1ps

module adc_capture_asserts (
  input logic fclk_ctr_clk,
  input logic rst,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic sample_valid_i,
  input logic snap_we_i,
  input logic done_i
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Ack two cycles after the access opens, never on the first one
  ack_delay: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    $rose(wb_cyc_i && wb_stb_i) |-> ##2 wb_ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o missing two cycles after stb rose");
    end

  ack_not_early: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    $rose(wb_cyc_i && wb_stb_i) |=> !wb_ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o one cycle after stb rose");
    end

  ack_pulse: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    wb_ack_i |=> !wb_ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o high for two cycles");
    end

  valid_pulse: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    sample_valid_i |=> !sample_valid_i)
    else begin
      fail_cnt++;
      $error("sample_valid_o high for two cycles");
    end

  we_with_valid: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    snap_we_i |-> sample_valid_i)
    else begin
      fail_cnt++;
      $error("snap_we_o without sample_valid_o");
    end

  no_write_done: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    done_i |-> !snap_we_i)
    else begin
      fail_cnt++;
      $error("snap_we_o while capture is done");
    end

  // First cycle out of reset
  quiet_after_reset: assert property (@(posedge fclk_ctr_clk)
    $fell(rst) |-> !sample_valid_i && !snap_we_i && !wb_ack_i)
    else begin
      fail_cnt++;
      $error("Outputs not low after reset");
    end

endmodule

bind adc_capture_top adc_capture_asserts asserts0 (
  .fclk_ctr_clk   (fclk_ctr_clk),
  .rst            (rst),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_ack_i       (wb_ack_o),
  .sample_valid_i (sample_valid_o),
  .snap_we_i      (snap_we_o),
  .done_i         (done)
);

// File: testbench/tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture;

  localparam int NUM_LANES      = 2;
  localparam int SNAP_ADDR_BITS = 6;
  localparam int DEPTH          = 1 << SNAP_ADDR_BITS;
  localparam int SW             = NUM_LANES * adc_pkg::SAMPLE_BITS;
  // Two captures of 64 samples at 5 cycles each plus bus traffic, with margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                               fclk_ctr_clk;
  logic                               rst;
  adc_pkg::bit_pair_t [NUM_LANES-1:0] lane_bits;
  logic                               frame;
  logic                               ext_trig;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  adc_pkg::bus_addr_t                 wb_adr;
  adc_pkg::bus_data_t                 wb_dat_w;
  adc_pkg::sample_t   [NUM_LANES-1:0] samples;
  logic                               sample_valid;
  logic                               snap_we;
  logic [SNAP_ADDR_BITS-1:0]          snap_addr;
  logic                               wb_ack;
  adc_pkg::bus_data_t                 wb_dat_r;

  int            cycle = 0;
  int            errors = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            test_err_base = 0;
  int            checked = 0;      // Samples compared so far
  int            cap_count = DEPTH;  // No capture expected before a trigger
  int            trig_cycle = 0;
  int            we_seen = 0;
  bit            stream_on = 1'b0;
  bit            inject_err = 1'b0;
  logic [SW-1:0] exp_q [$];
  logic [SW-1:0] exp_buf [DEPTH];

  adc_capture_top #(
    .NUM_LANES      (NUM_LANES),
    .SNAP_ADDR_BITS (SNAP_ADDR_BITS)
  ) dut0 (
    .fclk_ctr_clk   (fclk_ctr_clk),
    .rst            (rst),
    .lane_bits_i    (lane_bits),
    .frame_i        (frame),
    .ext_trig_i     (ext_trig),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .samples_o      (samples),
    .sample_valid_o (sample_valid),
    .snap_we_o      (snap_we),
    .snap_addr_o    (snap_addr),
    .wb_ack_o       (wb_ack),
    .wb_dat_o       (wb_dat_r)
  );

  initial begin
    fclk_ctr_clk = 1'b0;
    forever #5 fclk_ctr_clk = ~fclk_ctr_clk;
  end

  always @(posedge fclk_ctr_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  // One bus access, waits for ack and samples data mid-cycle
  task automatic bus_access(input logic we, input adc_pkg::bus_addr_t adr,
                            input adc_pkg::bus_data_t wdat, output adc_pkg::bus_data_t rdat);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge fclk_ctr_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge fclk_ctr_clk);
      wait_cnt++;
    end while (!wb_ack && wait_cnt < 8);
    if (!wb_ack) begin
      errors++;
      $display("Bus access to address %h got no ack", adr);
    end
    rdat = wb_dat_r;
    @(posedge fclk_ctr_clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input adc_pkg::bus_addr_t adr, input adc_pkg::bus_data_t wdat);
    adc_pkg::bus_data_t unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic read_check(input string name, input adc_pkg::bus_addr_t adr,
                            input adc_pkg::bus_data_t exp);
    adc_pkg::bus_data_t rd;
    bus_access(1'b0, adr, '0, rd);
    check_eq(name, rd, exp);
  endtask

  task automatic wait_done();
    adc_pkg::bus_data_t rd;
    int polls;
    polls = 0;
    do begin
      bus_access(1'b0, 12'h001, '0, rd);
      polls++;
    end while (!rd[1] && polls < 200);
    if (!rd[1]) begin
      errors++;
      $display("Capture did not reach done after %0d status reads", polls);
    end
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = checked + n;
    while (checked < target) @(posedge fclk_ctr_clk);
  endtask

  // Lane l carries bits 10l+9 down to 10l, MS pair first
  task automatic send_sample(input int pairs);
    logic [SW-1:0] word;
    word = SW'($urandom);
    for (int p = 0; p < pairs; p++) begin
      @(posedge fclk_ctr_clk);
      #1;
      frame = (p == 0);
      for (int l = 0; l < NUM_LANES; l++) begin
        lane_bits[l] = word[l*adc_pkg::SAMPLE_BITS + adc_pkg::SAMPLE_BITS - 2 - 2*p +: 2];
      end
    end
    if (pairs == adc_pkg::PAIRS_PER_SAMPLE) begin
      exp_q.push_back(word);
    end
  endtask

  task automatic finish_test(input int num, input string name);
    tests_run++;
    if (errors == test_err_base) begin
      $display("Test %0d %s: PASS", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  initial begin
    wait (stream_on);
    forever begin
      if (inject_err) begin
        send_sample(2);  // Next frame arrives early
        inject_err = 1'b0;
      end else begin
        send_sample(adc_pkg::PAIRS_PER_SAMPLE);
      end
    end
  end

  // Sample and capture strobe monitor
  always @(negedge fclk_ctr_clk) begin
    logic [SW-1:0] exp;
    bit            exp_we;
    exp_we = 1'b0;
    if (sample_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("sample_valid_o pulsed at %0t with no sample sent", $time);
      end else begin
        exp = exp_q.pop_front();
        check_eq("samples_o", 32'(samples), 32'(exp));
        checked++;
        exp_we = (cycle >= trig_cycle) && (cap_count < DEPTH);
        if (exp_we) begin
          check_eq("snap_addr_o", 32'(snap_addr), 32'(cap_count));
          exp_buf[cap_count] = exp;
          cap_count++;
        end
      end
    end
    check_eq("snap_we_o", 32'(snap_we), 32'(exp_we));
    if (snap_we) we_seen++;
  end

  initial begin
    void'($urandom(32'h2473f258));
    rst       = 1'b1;
    lane_bits = '0;
    frame     = 1'b0;
    ext_trig  = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (3) @(posedge fclk_ctr_clk);
    #1;
    rst = 1'b0;

    @(negedge fclk_ctr_clk);
    check_eq("sample_valid_o", 32'(sample_valid), 32'd0);
    check_eq("wb_ack_o", 32'(wb_ack), 32'd0);
    read_check("status", 12'h001, 32'd0);
    read_check("err_cnt lane 0", 12'h004, 32'd0);
    read_check("err_cnt lane 1", 12'h005, 32'd0);
    finish_test(1, "reset state");

    stream_on = 1'b1;
    wait_samples(20);
    finish_test(2, "sample assembly");

    inject_err = 1'b1;
    wait (!inject_err);
    wait_samples(10);
    read_check("err_cnt lane 0", 12'h004, 32'd1);
    read_check("err_cnt lane 1", 12'h005, 32'd1);
    finish_test(3, "frame error");

    bus_write(12'h000, 32'd1);
    trig_cycle = cycle;  // FSM is armed from this cycle on
    cap_count  = 0;
    we_seen    = 0;
    read_check("status busy", 12'h001, 32'd1);
    wait_done();
    read_check("status done", 12'h001, 32'd2);
    check_eq("snap_we_o count", 32'(we_seen), 32'(DEPTH));
    for (int a = 0; a < DEPTH; a++) begin
      read_check("buffer word", 12'h800 + 12'(a), 32'(exp_buf[a]));
    end
    finish_test(4, "software trigger capture");

    bus_write(12'h000, 32'd0);
    @(posedge fclk_ctr_clk);
    #1;
    ext_trig   = 1'b1;
    trig_cycle = cycle + 3;  // Two synchronizer flops, then the edge detect
    cap_count  = 0;
    we_seen    = 0;
    repeat (2) @(posedge fclk_ctr_clk);
    #1;
    ext_trig = 1'b0;
    wait_samples(8);
    read_check("status busy", 12'h001, 32'd1);
    bus_write(12'h000, 32'd1);  // Retrigger while capturing
    wait_done();
    check_eq("snap_we_o count", 32'(we_seen), 32'(DEPTH));
    for (int a = 0; a < DEPTH; a++) begin
      read_check("buffer word", 12'h800 + 12'(a), 32'(exp_buf[a]));
    end
    finish_test(5, "external trigger capture");

    $display("Tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut0.asserts0.fail_cnt);
    if (errors == 0 && tests_failed == 0 && dut0.asserts0.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: list.f
hw/adc_pkg.sv
hw/lane_deserializer.sv
hw/snapshot_ctrl.sv
hw/snapshot_buffer.sv
hw/adc_regs.sv
hw/adc_capture_top.sv
testbench/adc_capture_asserts.sv
testbench/tb_adc_capture.sv

// File: Makefile
SIM = obj_dir/Vtb_adc_capture

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): list.f $(wildcard hw/*.sv testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_capture -f list.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "Result: FAIL"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf obj_dir sim.log
